// ==== verilog/mcu_ao_settings.svh ====
/* widths and depths of the always-on peripheral block
   include at the top of any file that sizes ports or storage with these */
`ifndef MCU_AO_SETTINGS_SVH
`define MCU_AO_SETTINGS_SVH

`default_nettype none

// register bus
`define AO_DATA_W 32
`define AO_ADDR_W 8

// gpio bank
`define AO_GPIO_W 8

// flops between the pad and the first use of an input
`define AO_SYNC_STAGES 2

// machine timer
`define AO_TIMER_W 32

`default_nettype wire

`endif

// ==== verilog/mcu_ao_reg_pkg.sv ====
/* register map and bus word types of the always-on register bus
   imported by the bus interface, the register file and the GPIO logic */
`include "mcu_ao_settings.svh"
`default_nettype none

package mcu_ao_reg_pkg;

  // one bus word and one byte address
  typedef logic [`AO_DATA_W-1:0] ao_data_t;
  typedef logic [`AO_ADDR_W-1:0] ao_addr_t;

  // one bit per gpio pin
  typedef logic [`AO_GPIO_W-1:0] gpio_vec_t;

  // register byte addresses, word aligned
  typedef enum ao_addr_t {
    // gpio bank
    GPIO_OUT     = 'h00,
    GPIO_OE      = 'h04,
    GPIO_IN      = 'h08,
    GPIO_INTR_EN = 'h0C,
    // write-one-to-clear on write
    INTR_PENDING = 'h10,
    // machine timer
    TIMER_VALUE  = 'h14,
    TIMER_CMP    = 'h18,
    TIMER_CTRL   = 'h1C,
    // software interrupt and program exit
    SW_IRQ       = 'h20,
    EXIT_VALUE   = 'h24,
    EXIT_VALID   = 'h28
  } ao_reg_addr_e;

endpackage

`default_nettype wire

// ==== verilog/mcu_ao_irq_pkg.sv ====
/* interrupt vector layout as seen by the core
   import where the vector is built or decoded */
`default_nettype none

package mcu_ao_irq_pkg;

  // machine software interrupt
  localparam int IRQ_SOFTWARE_BIT = 3;

  // machine timer interrupt
  localparam int IRQ_TIMER_BIT = 7;

  // external interrupt, no source here so it reads zero
  localparam int IRQ_EXTERNAL_BIT = 11;

  // first fast interrupt, gpio pin i sits at IRQ_FAST_BASE + i
  localparam int IRQ_FAST_BASE = 16;

  // full vector handed to the core
  typedef logic [31:0] intr_vec_t;

endpackage

`default_nettype wire

// ==== verilog/reg_bus_if.sv ====
/* register bus between the top level and the register file
   the host drives the request, the device answers in the same cycle */
`timescale 1ns/1ns
`default_nettype none

interface reg_bus_if;
  import mcu_ao_reg_pkg::*;

  // request
  logic     valid;
  logic     write;
  ao_addr_t addr;
  ao_data_t wdata;

  // response
  logic     ready;
  ao_data_t rdata;
  logic     error;

  modport host (output valid, write, addr, wdata, input ready, rdata, error);

  modport device (input valid, write, addr, wdata, output ready, rdata, error);

endinterface

`default_nettype wire

// ==== verilog/ao_reg_file.sv ====
/* register file of the always-on bank, decodes the register bus
   holds the writable registers and turns timer and pending writes into strobes */
`include "mcu_ao_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module ao_reg_file (
  input  wire                              clk_i,
  input  wire                              rst_i,
  reg_bus_if.device                        bus,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   gpio_in_i,
  input  wire [`AO_TIMER_W-1:0]            timer_value_i,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   pending_i,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_out_o,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_oe_o,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_intr_en_o,
  output logic                             pending_clr_o,
  output mcu_ao_reg_pkg::gpio_vec_t        pending_clr_mask_o,
  output logic                             timer_load_o,
  output logic [`AO_TIMER_W-1:0]           timer_load_value_o,
  output logic [`AO_TIMER_W-1:0]           timer_cmp_o,
  output logic                             timer_en_o,
  output logic                             sw_irq_o,
  output logic                             exit_valid_o,
  output mcu_ao_reg_pkg::ao_data_t         exit_value_o
);
  import mcu_ao_reg_pkg::*;

  logic     addr_hit;
  logic     access_err;
  logic     wr_en;
  ao_data_t rdata;

  // read mux, anything not listed is outside the map
  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (bus.addr)
      GPIO_OUT:     rdata = ao_data_t'(gpio_out_o);
      GPIO_OE:      rdata = ao_data_t'(gpio_oe_o);
      GPIO_IN:      rdata = ao_data_t'(gpio_in_i);
      GPIO_INTR_EN: rdata = ao_data_t'(gpio_intr_en_o);
      INTR_PENDING: rdata = ao_data_t'(pending_i);
      TIMER_VALUE:  rdata = ao_data_t'(timer_value_i);
      TIMER_CMP:    rdata = ao_data_t'(timer_cmp_o);
      TIMER_CTRL:   rdata = ao_data_t'(timer_en_o);
      SW_IRQ:       rdata = ao_data_t'(sw_irq_o);
      EXIT_VALUE:   rdata = exit_value_o;
      EXIT_VALID:   rdata = ao_data_t'(exit_valid_o);
      default:      addr_hit = 1'b0;
    endcase
  end

  // gpio_in is read only
  assign access_err = !addr_hit || (bus.write && (bus.addr == GPIO_IN));
  assign wr_en      = bus.valid && bus.write && !access_err;

  // single cycle answer, no wait states
  assign bus.ready = bus.valid;
  assign bus.error = bus.valid && access_err;
  assign bus.rdata = access_err ? '0 : rdata;

  // these two registers are not stored here
  assign pending_clr_o      = wr_en && (bus.addr == INTR_PENDING);
  assign pending_clr_mask_o = bus.wdata[`AO_GPIO_W-1:0];
  assign timer_load_o       = wr_en && (bus.addr == TIMER_VALUE);
  assign timer_load_value_o = bus.wdata[`AO_TIMER_W-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_o     <= '0;
      gpio_oe_o      <= '0;
      gpio_intr_en_o <= '0;
      timer_cmp_o    <= '0;
      timer_en_o     <= 1'b0;
      sw_irq_o       <= 1'b0;
      exit_value_o   <= '0;
      exit_valid_o   <= 1'b0;
    end else if (wr_en) begin
      case (bus.addr)
        GPIO_OUT:     gpio_out_o     <= bus.wdata[`AO_GPIO_W-1:0];
        GPIO_OE:      gpio_oe_o      <= bus.wdata[`AO_GPIO_W-1:0];
        GPIO_INTR_EN: gpio_intr_en_o <= bus.wdata[`AO_GPIO_W-1:0];
        TIMER_CMP:    timer_cmp_o    <= bus.wdata[`AO_TIMER_W-1:0];
        // bit 0 is the enable
        TIMER_CTRL:   timer_en_o     <= bus.wdata[0];
        SW_IRQ:       sw_irq_o       <= bus.wdata[0];
        EXIT_VALUE:   exit_value_o   <= bus.wdata;
        EXIT_VALID:   exit_valid_o   <= bus.wdata[0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gpio_ctrl.sv ====
/* gpio input path, synchronizes the pads and finds rising edges
   one pulse on gpio_rise_o per low to high change of a pin */
`include "mcu_ao_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module gpio_ctrl (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   gpio_i,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_sync_o,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_rise_o
);
  import mcu_ao_reg_pkg::*;

  // stage 0 samples the pads
  gpio_vec_t sync_q [`AO_SYNC_STAGES];
  gpio_vec_t prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `AO_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
      prev_q <= '0;
    end else begin
      sync_q[0] <= gpio_i;
      for (int i = 1; i < `AO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      // last synchronized value, for edge detection
      prev_q <= sync_q[`AO_SYNC_STAGES-1];
    end
  end

  assign gpio_sync_o = sync_q[`AO_SYNC_STAGES-1];

  // high for the one cycle between the sync and prev updates
  assign gpio_rise_o = gpio_sync_o & ~prev_q;

endmodule

`default_nettype wire

// ==== verilog/ao_timer.sv ====
/* machine timer, counts up while enabled and compares against a limit
   a bus load overrides counting in the same cycle */
`include "mcu_ao_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module ao_timer (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     load_i,
  input  wire [`AO_TIMER_W-1:0]   load_value_i,
  input  wire [`AO_TIMER_W-1:0]   cmp_i,
  input  wire                     en_i,
  output logic [`AO_TIMER_W-1:0]  value_o,
  output logic                    expired_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      value_o <= '0;
    end else if (load_i) begin
      value_o <= load_value_i;
    end else if (en_i) begin
      // wraps at the top like mtime
      value_o <= value_o + 1'b1;
    end
  end

  // level, stays high until the counter is reloaded below the limit
  assign expired_o = (value_o >= cmp_i);

endmodule

`default_nettype wire

// ==== verilog/irq_ctrl.sv ====
/* gpio pending bits and the interrupt vector handed to the core
   pending bits are set by pin edges and cleared by write-one-to-clear */
`include "mcu_ao_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   gpio_rise_i,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   gpio_intr_en_i,
  input  wire                              clr_i,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   clr_mask_i,
  input  wire                              timer_expired_i,
  input  wire                              timer_en_i,
  input  wire                              sw_irq_i,
  output mcu_ao_reg_pkg::gpio_vec_t        pending_o,
  output mcu_ao_irq_pkg::intr_vec_t        intr_o
);
  import mcu_ao_reg_pkg::*;
  import mcu_ao_irq_pkg::*;

  gpio_vec_t clr_bits;

  assign clr_bits = clr_i ? clr_mask_i : '0;

  // set wins over clear when both hit the same pin
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_o <= '0;
    end else begin
      pending_o <= (pending_o & ~clr_bits) | gpio_rise_i;
    end
  end

  // unused positions stay zero
  always_comb begin
    intr_o                   = '0;
    intr_o[IRQ_SOFTWARE_BIT] = sw_irq_i;
    intr_o[IRQ_TIMER_BIT]    = timer_en_i & timer_expired_i;

    // the enable only masks the output and pending is kept regardless
    intr_o[IRQ_FAST_BASE +: `AO_GPIO_W] = pending_o & gpio_intr_en_i;
  end

endmodule

`default_nettype wire

// ==== verilog/mcu_ao_top.sv ====
/* top of the always-on peripheral bank
   plain register bus and pad ports outside, blocks wired together inside */
`include "mcu_ao_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module mcu_ao_top (
  input  wire                              clk_i,
  input  wire                              rst_i,
  input  wire                              reg_valid_i,
  input  wire                              reg_write_i,
  input  wire mcu_ao_reg_pkg::ao_addr_t    reg_addr_i,
  input  wire mcu_ao_reg_pkg::ao_data_t    reg_wdata_i,
  input  wire mcu_ao_reg_pkg::gpio_vec_t   gpio_i,
  output logic                             reg_ready_o,
  output mcu_ao_reg_pkg::ao_data_t         reg_rdata_o,
  output logic                             reg_error_o,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_o,
  output mcu_ao_reg_pkg::gpio_vec_t        gpio_oe_o,
  output mcu_ao_irq_pkg::intr_vec_t        intr_o,
  output logic                             exit_valid_o,
  output mcu_ao_reg_pkg::ao_data_t         exit_value_o
);
  import mcu_ao_reg_pkg::*;

  gpio_vec_t              gpio_sync;
  gpio_vec_t              gpio_rise;
  gpio_vec_t              gpio_intr_en;
  gpio_vec_t              pending;
  gpio_vec_t              pending_clr_mask;
  logic                   pending_clr;
  logic                   timer_load;
  logic                   timer_en;
  logic                   timer_expired;
  logic                   sw_irq;
  logic [`AO_TIMER_W-1:0] timer_load_value;
  logic [`AO_TIMER_W-1:0] timer_cmp;
  logic [`AO_TIMER_W-1:0] timer_value;

  reg_bus_if bus ();

  // this level acts as the bus host
  assign bus.valid   = reg_valid_i;
  assign bus.write   = reg_write_i;
  assign bus.addr    = reg_addr_i;
  assign bus.wdata   = reg_wdata_i;
  assign reg_ready_o = bus.ready;
  assign reg_rdata_o = bus.rdata;
  assign reg_error_o = bus.error;

  ao_reg_file u_reg_file (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .bus                (bus.device),
    .gpio_in_i          (gpio_sync),
    .timer_value_i      (timer_value),
    .pending_i          (pending),
    .gpio_out_o         (gpio_o),
    .gpio_oe_o          (gpio_oe_o),
    .gpio_intr_en_o     (gpio_intr_en),
    .pending_clr_o      (pending_clr),
    .pending_clr_mask_o (pending_clr_mask),
    .timer_load_o       (timer_load),
    .timer_load_value_o (timer_load_value),
    .timer_cmp_o        (timer_cmp),
    .timer_en_o         (timer_en),
    .sw_irq_o           (sw_irq),
    .exit_valid_o       (exit_valid_o),
    .exit_value_o       (exit_value_o)
  );

  gpio_ctrl u_gpio_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .gpio_i      (gpio_i),
    .gpio_sync_o (gpio_sync),
    .gpio_rise_o (gpio_rise)
  );

  ao_timer u_timer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .load_i       (timer_load),
    .load_value_i (timer_load_value),
    .cmp_i        (timer_cmp),
    .en_i         (timer_en),
    .value_o      (timer_value),
    .expired_o    (timer_expired)
  );

  irq_ctrl u_irq_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .gpio_rise_i     (gpio_rise),
    .gpio_intr_en_i  (gpio_intr_en),
    .clr_i           (pending_clr),
    .clr_mask_i      (pending_clr_mask),
    .timer_expired_i (timer_expired),
    .timer_en_i      (timer_en),
    .sw_irq_i        (sw_irq),
    .pending_o       (pending),
    .intr_o          (intr_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_mcu_ao.sv ====
/* testbench for the always-on peripheral bank that runs a step table against the DUT
   bus accesses, pad changes, waits and output checks are applied in table order */
`timescale 1ns/1ns
`default_nettype none

module tb_mcu_ao;
  import mcu_ao_reg_pkg::*;
  import mcu_ao_irq_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int TIMER_N      = 5;

  typedef enum int {K_WRITE, K_READ, K_WRITE_ERR, K_READ_ERR,
                    K_PADS, K_WAIT, K_CHECK} step_kind_e;

  // outputs a check step selects through its address column
  typedef enum int {O_GPIO, O_OE, O_INTR, O_EXIT_VALID, O_EXIT_VALUE} out_sel_e;

  logic      clk_i = 1'b0;
  logic      rst_i;
  logic      reg_valid_i;
  logic      reg_write_i;
  ao_addr_t  reg_addr_i;
  ao_data_t  reg_wdata_i;
  gpio_vec_t gpio_i;
  logic      reg_ready_o;
  ao_data_t  reg_rdata_o;
  logic      reg_error_o;
  gpio_vec_t gpio_o;
  gpio_vec_t gpio_oe_o;
  intr_vec_t intr_o;
  logic      exit_valid_o;
  ao_data_t  exit_value_o;

  // the data column of a check step is a mask
  string       name_q[$];
  step_kind_e  kind_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  int error_cnt   = 0;
  int check_cnt   = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  mcu_ao_top DUT (.*);

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic add_step(input string name, input step_kind_e kind,
                          input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] exp);
    name_q.push_back(name);
    kind_q.push_back(kind);
    addr_q.push_back(addr);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      error_cnt++;
    end
  endtask

  function automatic logic [31:0] output_value(input logic [31:0] sel);
    case (sel)
      O_GPIO:       return 32'(gpio_o);
      O_OE:         return 32'(gpio_oe_o);
      O_INTR:       return intr_o;
      O_EXIT_VALID: return 32'(exit_valid_o);
      default:      return exit_value_o;
    endcase
  endfunction

  task automatic run_step(input int idx);
    step_kind_e kind;
    logic       is_err;
    kind   = kind_q[idx];
    is_err = (kind == K_WRITE_ERR) || (kind == K_READ_ERR);
    @(negedge clk_i);
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    case (kind)
      K_PADS: gpio_i = gpio_vec_t'(data_q[idx]);
      K_WAIT: repeat (data_q[idx]) @(posedge clk_i);
      K_CHECK: begin
        #(CLK_PERIOD / 4);
        check_value(name_q[idx], exp_q[idx], output_value(addr_q[idx]) & data_q[idx]);
      end
      default: begin
        reg_valid_i = 1'b1;
        reg_write_i = (kind == K_WRITE) || (kind == K_WRITE_ERR);
        reg_addr_i  = ao_addr_t'(addr_q[idx]);
        reg_wdata_i = data_q[idx];
        // the combinational answer is sampled well before the rising edge
        #(CLK_PERIOD / 4);
        check_value({name_q[idx], " ready"}, 32'h1, 32'(reg_ready_o));
        check_value({name_q[idx], " error flag"}, 32'(is_err), 32'(reg_error_o));
        if (kind != K_WRITE) begin
          check_value(name_q[idx], exp_q[idx], reg_rdata_o);
        end
      end
    endcase
  endtask

  initial begin
    int          seed_ret;
    int          errs_before;
    int          total;
    logic [31:0] out_pat;
    logic [31:0] oe_pat;
    logic [31:0] pad_pat;
    logic [31:0] exit_pat;
    logic [31:0] fast_mask;
    logic [31:0] tmr_bit;
    logic [31:0] sw_bit;
    rst_i       = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    gpio_i      = '0;
    seed_ret    = $urandom(88798);
    out_pat     = $urandom() & 32'hFF;
    oe_pat      = $urandom() & 32'hFF;
    pad_pat     = $urandom() & 32'hFF;
    exit_pat    = $urandom();
    fast_mask   = 32'hFF << IRQ_FAST_BASE;
    tmr_bit     = 32'h1 << IRQ_TIMER_BIT;
    sw_bit      = 32'h1 << IRQ_SOFTWARE_BIT;

    add_step("reset gpio_oe", K_CHECK, O_OE, 32'hFF, 0);
    add_step("reset intr", K_CHECK, O_INTR, 32'hFFFF_FFFF, 0);
    add_step("reset exit_valid", K_CHECK, O_EXIT_VALID, 1, 0);
    add_step("gpio_out write", K_WRITE, GPIO_OUT, out_pat, 0);
    add_step("gpio_oe write", K_WRITE, GPIO_OE, oe_pat, 0);
    add_step("gpio_out readback", K_READ, GPIO_OUT, 0, out_pat);
    add_step("gpio_oe readback", K_READ, GPIO_OE, 0, oe_pat);
    add_step("gpio_o pins", K_CHECK, O_GPIO, 32'hFF, out_pat);
    add_step("gpio_oe_o pins", K_CHECK, O_OE, 32'hFF, oe_pat);
    // every high pad is a fresh edge while no pin is enabled yet
    add_step("random pads", K_PADS, 0, pad_pat, 0);
    add_step("pad settle", K_WAIT, 0, 3, 0);
    add_step("gpio_in read", K_READ, GPIO_IN, 0, pad_pat);
    add_step("pending while disabled", K_READ, INTR_PENDING, 0, pad_pat);
    add_step("pads low", K_PADS, 0, 0, 0);
    add_step("clear all pending", K_WRITE, INTR_PENDING, 32'hFF, 0);
    add_step("pending cleared", K_READ, INTR_PENDING, 0, 0);
    // pin 0 enabled and pin 4 disabled
    add_step("enable pins 0-3", K_WRITE, GPIO_INTR_EN, 32'h0F, 0);
    add_step("rise pins 0 and 4", K_PADS, 0, 32'h11, 0);
    add_step("edge wait", K_WAIT, 0, 3, 0);
    add_step("gpio irq vector", K_CHECK, O_INTR, fast_mask, 32'h1 << IRQ_FAST_BASE);
    add_step("pending 0 and 4", K_READ, INTR_PENDING, 0, 32'h11);
    add_step("clear pin 0", K_WRITE, INTR_PENDING, 32'h01, 0);
    add_step("pin 4 still pending", K_READ, INTR_PENDING, 0, 32'h10);
    add_step("gpio irq gone", K_CHECK, O_INTR, fast_mask, 0);
    add_step("timer load zero", K_WRITE, TIMER_VALUE, 0, 0);
    add_step("timer compare", K_WRITE, TIMER_CMP, TIMER_N, 0);
    add_step("timer enable", K_WRITE, TIMER_CTRL, 1, 0);
    add_step("timer irq low", K_CHECK, O_INTR, tmr_bit, 0);
    add_step("timer run", K_WAIT, 0, TIMER_N + 2, 0);
    add_step("timer irq high", K_CHECK, O_INTR, tmr_bit, tmr_bit);
    add_step("timer disable", K_WRITE, TIMER_CTRL, 0, 0);
    // counted on every edge from the enable write to the disable write
    add_step("timer held first", K_READ, TIMER_VALUE, 0, TIMER_N + 5);
    add_step("timer held second", K_READ, TIMER_VALUE, 0, TIMER_N + 5);
    add_step("sw irq set", K_WRITE, SW_IRQ, 1, 0);
    add_step("sw irq high", K_CHECK, O_INTR, sw_bit, sw_bit);
    add_step("sw irq clear", K_WRITE, SW_IRQ, 0, 0);
    add_step("sw irq low", K_CHECK, O_INTR, sw_bit, 0);
    add_step("exit value write", K_WRITE, EXIT_VALUE, exit_pat, 0);
    add_step("exit valid write", K_WRITE, EXIT_VALID, 1, 0);
    add_step("exit_value_o", K_CHECK, O_EXIT_VALUE, 32'hFFFF_FFFF, exit_pat);
    add_step("exit_valid_o", K_CHECK, O_EXIT_VALID, 1, 1);
    add_step("unmapped read", K_READ_ERR, 32'h2C, 0, 0);
    add_step("unmapped write", K_WRITE_ERR, 32'h40, $urandom(), 0);
    add_step("gpio_in write", K_WRITE_ERR, GPIO_IN, $urandom(), 0);
    add_step("gpio_out after errors", K_READ, GPIO_OUT, 0, out_pat);
    add_step("exit value after errors", K_READ, EXIT_VALUE, 0, exit_pat);

    total = RESET_CYCLES + 1;
    foreach (kind_q[i]) begin
      total += (kind_q[i] == K_WAIT) ? int'(data_q[i]) : 1;
    end
    cycle_limit = 2 * total;

    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (int i = 0; i < name_q.size(); i++) begin
      errs_before = error_cnt;
      run_step(i);
      if (error_cnt == errs_before) begin
        $display("ok        %s", name_q[i]);
      end else begin
        $display("mismatch  %s", name_q[i]);
      end
    end
    @(negedge clk_i);
    reg_valid_i = 1'b0;

    $display("%0d tests, %0d checks, %0d errors", name_q.size(), check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/mcu_ao_reg_pkg.sv
verilog/mcu_ao_irq_pkg.sv
verilog/reg_bus_if.sv
verilog/ao_reg_file.sv
verilog/gpio_ctrl.sv
verilog/ao_timer.sv
verilog/irq_ctrl.sv
verilog/mcu_ao_top.sv
testbench/tb_mcu_ao.sv

// ==== Bender.yml ====
package:
  name: mcu_ao

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mcu_ao_reg_pkg.sv
      - verilog/mcu_ao_irq_pkg.sv
      - verilog/reg_bus_if.sv
      - verilog/ao_reg_file.sv
      - verilog/gpio_ctrl.sv
      - verilog/ao_timer.sv
      - verilog/irq_ctrl.sv
      - verilog/mcu_ao_top.sv
  - target: simulation
    files:
      - testbench/tb_mcu_ao.sv
